// File: verilog.f
core_pkg.sv
fetch_stage.sv
decode_stage.sv
regfile.sv
exec_unit.sv
hazard_ctrl.sv
mem_arbiter.sv
core_top.sv
tb_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -f verilog.f \
    -o sim_tb_core > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb_core > sim.log 2>&1
cat sim.log

grep -q "sim failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "sim passed" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0

// File: tb_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core import core_pkg::*;;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int DRAIN_CYCLES   = 30;

    logic      clk_i;
    logic      rstn_i;
    word_t     mem_rdata_i;
    logic      mem_req_o;
    logic      mem_we_o;
    addr_t     mem_addr_o;
    word_t     mem_wdata_o;
    logic      retire_valid_o;
    reg_addr_t retire_rd_o;
    word_t     retire_data_o;

    // Word-addressed memory model and its pending read
    word_t mem [0:255];
    word_t rd_pending;

    // Program and expected results
    word_t prog [0:31];
    int    n_prog;
    logic  exp_is_store [0:31];
    word_t exp_key [0:31];
    word_t exp_val [0:31];
    int    n_exp;

    // Observed events
    reg_addr_t ret_rd_q [$];
    word_t     ret_data_q [$];
    addr_t     st_addr_q [$];
    word_t     st_data_q [$];
    logic      seen_first_req;
    addr_t     first_req_addr;

    core_top uut (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .mem_rdata_i    (mem_rdata_i),
        .mem_req_o      (mem_req_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    // Memory answers one cycle after the request, driven mid-cycle
    always @(negedge clk_i) begin
        mem_rdata_i <= rd_pending;
        if (mem_req_o) begin
            if (!seen_first_req) begin
                seen_first_req = 1'b1;
                first_req_addr = mem_addr_o;
            end
            if (mem_we_o) begin
                mem[mem_addr_o[9:2]] = mem_wdata_o;
                st_addr_q.push_back(mem_addr_o);
                st_data_q.push_back(mem_wdata_o);
            end else begin
                rd_pending = mem[mem_addr_o[9:2]];
            end
        end
        if (rstn_i && retire_valid_o) begin
            if (retire_rd_o == '0) begin
                $display("A write to x0 was retired");
                stop_run();
            end
            ret_rd_q.push_back(retire_rd_o);
            ret_data_q.push_back(retire_data_o);
        end
    end

    task automatic check_idle(input logic got_req, input logic got_valid);
        if (got_req !== 1'b0) begin
            $display("FAIL mem_req_o: expected 0x0, got 0x%h", got_req);
            stop_run();
        end
        if (got_valid !== 1'b0) begin
            $display("FAIL retire_valid_o: expected 0x0, got 0x%h", got_valid);
            stop_run();
        end
    endtask

    task automatic check_retire(input reg_addr_t exp_rd, input word_t exp_data,
                                input reg_addr_t got_rd, input word_t got_data);
        if (got_rd !== exp_rd) begin
            $display("FAIL retire_rd_o: expected 0x%h, got 0x%h", exp_rd, got_rd);
            stop_run();
        end
        if (got_data !== exp_data) begin
            $display("FAIL retire_data_o: expected 0x%h, got 0x%h", exp_data, got_data);
            stop_run();
        end
    endtask

    task automatic check_store(input addr_t exp_addr, input word_t exp_data,
                               input addr_t got_addr, input word_t got_data);
        if (got_addr !== exp_addr) begin
            $display("FAIL mem_addr_o: expected 0x%h, got 0x%h", exp_addr, got_addr);
            stop_run();
        end
        if (got_data !== exp_data) begin
            $display("FAIL mem_wdata_o: expected 0x%h, got 0x%h", exp_data, got_data);
            stop_run();
        end
    endtask

    task automatic check_fetch_addr(input addr_t exp_addr, input addr_t got_addr);
        if (got_addr !== exp_addr) begin
            $display("FAIL mem_addr_o: expected 0x%h, got 0x%h", exp_addr, got_addr);
            stop_run();
        end
    endtask

    // Instruction encoders
    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_addi(input logic [11:0] imm, input reg_addr_t rs1,
                                       input reg_addr_t rd);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic word_t enc_lui(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t enc_lw(input logic [11:0] imm, input reg_addr_t rs1,
                                     input reg_addr_t rd);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t enc_sw(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_beq(input logic [12:0] imm, input reg_addr_t rs2,
                                      input reg_addr_t rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_jal(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic add_instr(input word_t w);
        prog[n_prog] = w;
        n_prog++;
    endtask

    task automatic add_retire(input reg_addr_t rd, input word_t val);
        exp_is_store[n_exp] = 1'b0;
        exp_key[n_exp]      = {27'b0, rd};
        exp_val[n_exp]      = val;
        n_exp++;
    endtask

    task automatic add_store(input addr_t addr, input word_t val);
        exp_is_store[n_exp] = 1'b1;
        exp_key[n_exp]      = addr;
        exp_val[n_exp]      = val;
        n_exp++;
    endtask

    initial begin
        word_t       rnd;
        logic [19:0] h1;
        logic [19:0] h2;
        logic [11:0] l1;
        logic [11:0] l2;
        word_t       v1;
        word_t       v2;
        word_t       x3;
        word_t       x4;
        word_t       x7;
        reg_addr_t   got_rd;
        word_t       got_data;
        addr_t       got_addr;
        int          t;

        clk_i          = 1'b0;
        rstn_i         = 1'b0;
        mem_rdata_i    = '0;
        rd_pending     = '0;
        seen_first_req = 1'b0;
        first_req_addr = '0;
        n_prog         = 0;
        n_exp          = 0;
        rnd            = $urandom(77019);

        rnd = $urandom;
        h1  = rnd[19:0];
        rnd = $urandom;
        l1  = rnd[11:0];
        rnd = $urandom;
        h2  = rnd[19:0];
        rnd = $urandom;
        l2  = rnd[11:0];
        v1  = {h1, 12'b0} + sext12(l1);
        v2  = {h2, 12'b0} + sext12(l2);
        x3  = v1 + v2;
        x4  = v1 - v2;
        x7  = x3 ^ x4;

        // ALU section, with back-to-back dependencies
        add_instr(enc_lui(h1, 5'd1));
        add_retire(5'd1, {h1, 12'b0});
        add_instr(enc_addi(l1, 5'd1, 5'd1));
        add_retire(5'd1, v1);
        add_instr(enc_lui(h2, 5'd2));
        add_retire(5'd2, {h2, 12'b0});
        add_instr(enc_addi(l2, 5'd2, 5'd2));
        add_retire(5'd2, v2);
        add_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        add_retire(5'd3, x3);
        add_instr(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        add_retire(5'd4, x4);
        add_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        add_retire(5'd5, v1 & v2);
        add_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        add_retire(5'd6, v1 | v2);
        add_instr(enc_r(7'h00, 5'd4, 5'd3, 3'b100, 5'd7));
        add_retire(5'd7, x7);
        add_instr(enc_addi(12'd5, 5'd1, 5'd0));
        // Store then load back through the shared port
        add_instr(enc_addi(12'h100, 5'd0, 5'd8));
        add_retire(5'd8, 32'h100);
        add_instr(enc_sw(12'd4, 5'd7, 5'd8));
        add_store(32'h104, x7);
        add_instr(enc_lw(12'd4, 5'd8, 5'd9));
        add_retire(5'd9, x7);
        add_instr(enc_addi(12'd1, 5'd9, 5'd10));
        add_retire(5'd10, x7 + 32'd1);
        // Taken BEQ skips one, not-taken BEQ falls through
        add_instr(enc_beq(13'd8, 5'd1, 5'd1));
        add_instr(enc_addi(12'h55, 5'd0, 5'd11));
        add_instr(enc_beq(13'd8, 5'd0, 5'd8));
        add_instr(enc_addi(12'd7, 5'd0, 5'd12));
        add_retire(5'd12, 32'd7);
        // JAL at pc 72 links 76 and skips one
        add_instr(enc_jal(21'd8, 5'd13));
        add_retire(5'd13, 32'd76);
        add_instr(enc_addi(12'd9, 5'd0, 5'd14));
        add_instr(enc_addi(12'd3, 5'd13, 5'd15));
        add_retire(5'd15, 32'd79);
        add_instr(enc_jal(21'd0, 5'd0));

        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hA5C3_0000 ^ (word_t'(i) << 2) ^ (word_t'(i) << 24);
        end
        for (int i = 0; i < n_prog; i++) begin
            mem[i] = prog[i];
        end

        repeat (5) begin
            @(negedge clk_i);
            check_idle(mem_req_o, retire_valid_o);
        end
        rstn_i = 1'b1;

        for (t = 0; t < TIMEOUT_CYCLES && !seen_first_req; t++) @(posedge clk_i);
        if (!seen_first_req) begin
            $display("Timed out waiting for the first memory request");
            stop_run();
        end
        check_fetch_addr(RESET_PC, first_req_addr);

        for (int i = 0; i < n_exp; i++) begin
            if (exp_is_store[i]) begin
                for (t = 0; t < TIMEOUT_CYCLES && st_addr_q.size() == 0; t++) @(posedge clk_i);
                if (st_addr_q.size() == 0) begin
                    $display("Timed out waiting for store %0d", i);
                    stop_run();
                end
                got_addr = st_addr_q.pop_front();
                got_data = st_data_q.pop_front();
                check_store(exp_key[i], exp_val[i], got_addr, got_data);
            end else begin
                for (t = 0; t < TIMEOUT_CYCLES && ret_rd_q.size() == 0; t++) @(posedge clk_i);
                if (ret_rd_q.size() == 0) begin
                    $display("Timed out waiting for retire entry %0d", i);
                    stop_run();
                end
                got_rd   = ret_rd_q.pop_front();
                got_data = ret_data_q.pop_front();
                check_retire(exp_key[i][4:0], exp_val[i], got_rd, got_data);
            end
        end

        // Skipped instructions must never show up
        repeat (DRAIN_CYCLES) @(posedge clk_i);
        if (ret_rd_q.size() != 0 || st_addr_q.size() != 0) begin
            $display("Unexpected retire or store after the last expected entry");
            $display("sim failed");
            $fatal(1, "extra activity after program end");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  word_t     mem_rdata_i,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output addr_t     mem_addr_o,
    output word_t     mem_wdata_o,
    output logic      retire_valid_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_data_o
);

    // Fetch side of the memory port
    logic      fetch_req;
    addr_t     fetch_addr;
    logic      fetch_gnt;
    logic      fetch_rvalid;

    // Data side of the memory port
    logic      data_req;
    logic      data_we;
    addr_t     data_addr;
    word_t     data_wdata;
    logic      data_gnt;
    logic      data_rvalid;

    // Fetch to decode
    logic      if_valid;
    addr_t     if_pc;
    word_t     if_instr;

    // Decode and register read
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    op_e       dec_op;

    // Decode to execute
    logic      ex_valid;
    op_e       ex_op;
    reg_addr_t ex_rd;
    word_t     ex_imm;
    addr_t     ex_pc;
    word_t     ex_a;
    word_t     ex_b;

    // Control
    logic      busy;
    logic      redirect;
    addr_t     redirect_pc;
    logic      stall_fetch;
    logic      stall_decode;
    logic      flush;

    fetch_stage u_fetch (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .stall_i       (stall_fetch),
        .flush_i       (flush),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .gnt_i         (fetch_gnt),
        .rvalid_i      (fetch_rvalid),
        .rdata_i       (mem_rdata_i),
        .req_o         (fetch_req),
        .addr_o        (fetch_addr),
        .valid_o       (if_valid),
        .pc_o          (if_pc),
        .instr_o       (if_instr)
    );

    decode_stage u_decode (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .stall_i    (stall_decode),
        .flush_i    (flush),
        .valid_i    (if_valid),
        .pc_i       (if_pc),
        .instr_i    (if_instr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .dec_op_o   (dec_op),
        .valid_o    (ex_valid),
        .op_o       (ex_op),
        .rd_o       (ex_rd),
        .imm_o      (ex_imm),
        .pc_o       (ex_pc),
        .a_o        (ex_a),
        .b_o        (ex_b)
    );

    // Writeback is taken straight from the retire port
    regfile u_regfile (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .we_i     (retire_valid_o),
        .waddr_i  (retire_rd_o),
        .wdata_i  (retire_data_o),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    exec_unit u_exec (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .valid_i       (ex_valid),
        .op_i          (ex_op),
        .rd_i          (ex_rd),
        .imm_i         (ex_imm),
        .pc_i          (ex_pc),
        .a_i           (ex_a),
        .b_i           (ex_b),
        .gnt_i         (data_gnt),
        .rvalid_i      (data_rvalid),
        .rdata_i       (mem_rdata_i),
        .req_o         (data_req),
        .we_o          (data_we),
        .addr_o        (data_addr),
        .wdata_o       (data_wdata),
        .busy_o        (busy),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .wb_valid_o    (retire_valid_o),
        .wb_rd_o       (retire_rd_o),
        .wb_data_o     (retire_data_o)
    );

    hazard_ctrl u_hazard (
        .dec_valid_i    (if_valid),
        .dec_rs1_i      (rs1),
        .dec_rs2_i      (rs2),
        .dec_op_i       (dec_op),
        .ex_valid_i     (ex_valid),
        .ex_op_i        (ex_op),
        .ex_rd_i        (ex_rd),
        .wb_valid_i     (retire_valid_o),
        .wb_rd_i        (retire_rd_o),
        .busy_i         (busy),
        .redirect_i     (redirect),
        .stall_fetch_o  (stall_fetch),
        .stall_decode_o (stall_decode),
        .flush_o        (flush)
    );

    mem_arbiter u_arbiter (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .fetch_req_i    (fetch_req),
        .fetch_addr_i   (fetch_addr),
        .data_req_i     (data_req),
        .data_we_i      (data_we),
        .data_addr_i    (data_addr),
        .data_wdata_i   (data_wdata),
        .fetch_gnt_o    (fetch_gnt),
        .data_gnt_o     (data_gnt),
        .fetch_rvalid_o (fetch_rvalid),
        .data_rvalid_o  (data_rvalid),
        .mem_req_o      (mem_req_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o)
    );

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import core_pkg::*; (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  fetch_req_i,
    input  addr_t fetch_addr_i,
    input  logic  data_req_i,
    input  logic  data_we_i,
    input  addr_t data_addr_i,
    input  word_t data_wdata_i,
    output logic  fetch_gnt_o,
    output logic  data_gnt_o,
    output logic  fetch_rvalid_o,
    output logic  data_rvalid_o,
    output logic  mem_req_o,
    output logic  mem_we_o,
    output addr_t mem_addr_o,
    output word_t mem_wdata_o
);

    owner_e owner_q;

    // Fixed priority, data before fetch
    assign data_gnt_o  = data_req_i;
    assign fetch_gnt_o = fetch_req_i && !data_req_i;

    assign mem_req_o   = data_req_i || fetch_req_i;
    assign mem_we_o    = data_req_i && data_we_i;
    assign mem_addr_o  = data_req_i ? data_addr_i : fetch_addr_i;
    assign mem_wdata_o = data_wdata_i;

    // Writes return nothing, so they leave no owner
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            owner_q <= OWN_NONE;
        end else if (data_gnt_o && !data_we_i) begin
            owner_q <= OWN_DATA;
        end else if (fetch_gnt_o) begin
            owner_q <= OWN_FETCH;
        end else begin
            owner_q <= OWN_NONE;
        end
    end

    assign fetch_rvalid_o = (owner_q == OWN_FETCH);
    assign data_rvalid_o  = (owner_q == OWN_DATA);

    // A fetch that lost the port retries with the same address
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        ($past(fetch_req_i && !fetch_gnt_o) && fetch_req_i) |->
            (fetch_addr_i == $past(fetch_addr_i)))
        else $error("mem_arbiter: denied fetch changed its address");

endmodule

`default_nettype wire

// File: hazard_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_ctrl import core_pkg::*; (
    input  logic      dec_valid_i,
    input  reg_addr_t dec_rs1_i,
    input  reg_addr_t dec_rs2_i,
    input  op_e       dec_op_i,
    input  logic      ex_valid_i,
    input  op_e       ex_op_i,
    input  reg_addr_t ex_rd_i,
    input  logic      wb_valid_i,
    input  reg_addr_t wb_rd_i,
    input  logic      busy_i,
    input  logic      redirect_i,
    output logic      stall_fetch_o,
    output logic      stall_decode_o,
    output logic      flush_o
);

    logic uses_rs1;
    logic uses_rs2;
    logic ex_writes;
    logic raw_ex;
    logic raw_wb;
    logic stall;

    // Only sources the op really reads count
    assign uses_rs1 = dec_op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                       OP_ADDI, OP_LW, OP_SW, OP_BEQ};
    assign uses_rs2 = dec_op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                       OP_SW, OP_BEQ};

    assign ex_writes = ex_valid_i && (ex_rd_i != '0) &&
                       !(ex_op_i inside {OP_NOP, OP_SW, OP_BEQ});

    assign raw_ex = ex_writes && ((uses_rs1 && dec_rs1_i == ex_rd_i) ||
                                  (uses_rs2 && dec_rs2_i == ex_rd_i));
    assign raw_wb = wb_valid_i && (wb_rd_i != '0) &&
                    ((uses_rs1 && dec_rs1_i == wb_rd_i) ||
                     (uses_rs2 && dec_rs2_i == wb_rd_i));

    // No forwarding, so wait until the value sits in the register file
    assign stall = !redirect_i && ((dec_valid_i && (raw_ex || raw_wb)) || busy_i);

    assign stall_fetch_o  = stall;
    assign stall_decode_o = stall;
    assign flush_o        = redirect_i;

endmodule

`default_nettype wire

// File: exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      valid_i,
    input  op_e       op_i,
    input  reg_addr_t rd_i,
    input  word_t     imm_i,
    input  addr_t     pc_i,
    input  word_t     a_i,
    input  word_t     b_i,
    input  logic      gnt_i,
    input  logic      rvalid_i,
    input  word_t     rdata_i,
    output logic      req_o,
    output logic      we_o,
    output addr_t     addr_o,
    output word_t     wdata_o,
    output logic      busy_o,
    output logic      redirect_o,
    output addr_t     redirect_pc_o,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    logic      is_load;
    logic      is_store;
    logic      writes_rd;
    word_t     result;
    logic      ld_pend_q;
    reg_addr_t ld_rd_q;

    assign is_load  = valid_i && (op_i == OP_LW);
    assign is_store = valid_i && (op_i == OP_SW);

    always_comb begin
        case (op_i)
            OP_ADD:  result = a_i + b_i;
            OP_SUB:  result = a_i - b_i;
            OP_AND:  result = a_i & b_i;
            OP_OR:   result = a_i | b_i;
            OP_XOR:  result = a_i ^ b_i;
            OP_ADDI: result = a_i + imm_i;
            OP_LUI:  result = imm_i;
            OP_JAL:  result = pc_i + 32'd4;
            default: result = '0;
        endcase
    end

    assign writes_rd = valid_i && (rd_i != '0) &&
                       (op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                     OP_ADDI, OP_LUI, OP_JAL});

    // Loads and stores go out straight from execute
    assign req_o   = is_load || is_store;
    assign we_o    = is_store;
    assign addr_o  = a_i + imm_i;
    assign wdata_o = b_i;

    // Data side wins the port, so a store normally goes in one cycle
    assign busy_o = is_load || (is_store && !gnt_i) || ld_pend_q;

    assign redirect_o    = valid_i && ((op_i == OP_JAL) || (op_i == OP_BEQ && a_i == b_i));
    assign redirect_pc_o = pc_i + imm_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ld_pend_q  <= 1'b0;
            wb_valid_o <= 1'b0;
        end else begin
            if (is_load && gnt_i) begin
                ld_pend_q <= 1'b1;
            end else if (rvalid_i) begin
                ld_pend_q <= 1'b0;
            end
            wb_valid_o <= writes_rd || (rvalid_i && ld_pend_q && ld_rd_q != '0);
        end
    end

    always_ff @(posedge clk_i) begin
        if (is_load && gnt_i) begin
            ld_rd_q <= rd_i;
        end
        if (rvalid_i) begin
            wb_rd_o   <= ld_rd_q;
            wb_data_o <= rdata_i;
        end else begin
            wb_rd_o   <= rd_i;
            wb_data_o <= result;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i) rvalid_i |-> ld_pend_q)
        else $error("exec_unit: data response with no load pending");

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [1:31];

    always_ff @(posedge clk_i) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero, a same-cycle write bypasses the array
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

    // Execute suppresses x0 results before they reach the retire port
    assert property (@(posedge clk_i) disable iff (!rstn_i) we_i |-> waddr_i != '0)
        else $error("regfile: retired write to x0");

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      stall_i,
    input  logic      flush_i,
    input  logic      valid_i,
    input  addr_t     pc_i,
    input  word_t     instr_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output op_e       dec_op_o,
    output logic      valid_o,
    output op_e       op_o,
    output reg_addr_t rd_o,
    output word_t     imm_o,
    output addr_t     pc_o,
    output word_t     a_o,
    output word_t     b_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_e        op_d;
    word_t      imm_d;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        op_d  = OP_NOP;
        imm_d = '0;
        case (opcode)
            OPC_REG: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: op_d = OP_ADD;
                        3'b100: op_d = OP_XOR;
                        3'b110: op_d = OP_OR;
                        3'b111: op_d = OP_AND;
                        default: op_d = OP_NOP;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op_d = OP_SUB;
                end
            end
            OPC_IMM: begin
                if (funct3 == 3'b000) op_d = OP_ADDI;
                imm_d = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            OPC_LUI: begin
                op_d  = OP_LUI;
                imm_d = {instr_i[31:12], 12'b0};
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) op_d = OP_LW;
                imm_d = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) op_d = OP_SW;
                imm_d = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000) op_d = OP_BEQ;
                imm_d = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                op_d  = OP_JAL;
                imm_d = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: op_d = OP_NOP;
        endcase
    end

    // Register read happens in this stage
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];
    assign dec_op_o = op_d;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
            op_o    <= OP_NOP;
        end else if (flush_i || stall_i) begin
            valid_o <= 1'b0;
            op_o    <= OP_NOP;
        end else begin
            // Unknown encodings go down as bubbles
            valid_o <= valid_i && (op_d != OP_NOP);
            op_o    <= op_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            rd_o  <= instr_i[11:7];
            imm_o <= imm_d;
            pc_o  <= pc_i;
            a_o   <= rs1_data_i;
            b_o   <= rs2_data_i;
        end
    end

endmodule

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage import core_pkg::*; (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  stall_i,
    input  logic  flush_i,
    input  logic  redirect_i,
    input  addr_t redirect_pc_i,
    input  logic  gnt_i,
    input  logic  rvalid_i,
    input  word_t rdata_i,
    output logic  req_o,
    output addr_t addr_o,
    output logic  valid_o,
    output addr_t pc_o,
    output word_t instr_o
);

    addr_t pc_q;
    logic  run_q;
    logic  pending_q;
    logic  stale_q;
    logic  fetch_go;
    logic  out_load;
    logic  valid_q;
    addr_t pc_out_q;
    word_t instr_q;

    // One fetch in flight at a time, none until out of reset
    assign req_o    = run_q && !stall_i && !pending_q;
    assign addr_o   = pc_q;
    assign fetch_go = req_o && gnt_i;

    // Output slot is free or drains this cycle
    assign out_load = !valid_q || !stall_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q      <= RESET_PC;
            run_q     <= 1'b0;
            pending_q <= 1'b0;
            stale_q   <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (fetch_go) begin
                pc_q <= pc_q + 32'd4;
            end
            // A fetch granted during a redirect is on the old path
            if (fetch_go) begin
                pending_q <= 1'b1;
                stale_q   <= redirect_i;
            end else if (rvalid_i) begin
                pending_q <= 1'b0;
                stale_q   <= 1'b0;
            end
            if (flush_i) begin
                valid_q <= 1'b0;
            end else if (out_load) begin
                valid_q <= rvalid_i && !stale_q;
            end
        end
    end

    // PC already moved on by four when the data returns
    always_ff @(posedge clk_i) begin
        if (rvalid_i && out_load) begin
            pc_out_q <= pc_q - 32'd4;
            instr_q  <= rdata_i;
        end
    end

    assign valid_o = valid_q;
    assign pc_o    = pc_out_q;
    assign instr_o = instr_q;

endmodule

`default_nettype wire

// File: core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [4:0]      reg_addr_t;

    // Fetch starts here after reset
    localparam addr_t RESET_PC = '0;

    // RV32I major opcodes for the supported subset
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Decoded operation, OP_NOP marks a bubble
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_JAL
    } op_e;

    // Who the next read response belongs to
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_DATA
    } owner_e;

endpackage

`default_nettype wire
